// File: dv/triangle_asserts.sv
/* Wishbone, clip and status rules for triangle_top, bound into every instance
   all checks are held off while rst_n is low */
`timescale 1ns/1ps

module triangle_asserts #(
    parameter int FB_WIDTH  = 320,
    parameter int FB_HEIGHT = 240
) (
    input logic                  clk_100m,
    input logic                  rst_n,
    input gfx_types_pkg::wb_wr_t wb,
    input logic                  wb_ack,
    input logic                  drawing,
    input logic                  draw_done
);
    import gfx_types_pkg::*;

    localparam int FB_PIXELS = FB_WIDTH * FB_HEIGHT;

    int fail_cnt = 0;  // failed assertions so far

    stb_with_cyc: assert property (@(posedge clk_100m) disable iff (!rst_n)
        wb.stb |-> wb.cyc)
    else begin
        $error("wishbone stb raised without cyc");
        fail_cnt++;
    end

    // adr and dat frozen while a strobe waits for ack
    hold_until_ack: assert property (@(posedge clk_100m) disable iff (!rst_n)
        (wb.cyc && wb.stb && !wb_ack) |=> ($stable(wb.adr) && $stable(wb.dat)))
    else begin
        $error("wishbone adr or dat changed before ack");
        fail_cnt++;
    end

    ack_with_stb: assert property (@(posedge clk_100m) disable iff (!rst_n)
        wb_ack |-> (wb.cyc && wb.stb))
    else begin
        $error("wishbone ack without an active strobe");
        fail_cnt++;
    end

    write_in_fb: assert property (@(posedge clk_100m) disable iff (!rst_n)
        (wb.cyc && wb.stb) |-> (wb.adr < fb_addr_t'(FB_PIXELS)))
    else begin
        $error("write address outside the framebuffer");
        fail_cnt++;
    end

    busy_xor_done: assert property (@(posedge clk_100m) disable iff (!rst_n)
        !(drawing && draw_done))
    else begin
        $error("drawing and draw_done high together");
        fail_cnt++;
    end

    done_sticky: assert property (@(posedge clk_100m) disable iff (!rst_n)
        draw_done |=> draw_done)
    else begin
        $error("draw_done fell before reset");
        fail_cnt++;
    end

endmodule

bind triangle_top triangle_asserts #(
    .FB_WIDTH (FB_WIDTH),
    .FB_HEIGHT(FB_HEIGHT)
) i_triangle_asserts (
    .clk_100m (clk_100m),
    .rst_n    (rst_n),
    .wb       (wb),
    .wb_ack   (wb_ack),
    .drawing  (drawing),
    .draw_done(draw_done)
);

// File: dv/triangle_tb.sv
/* testbench for triangle_top with a four-frame wait and 200-cycle frames
   bus and status rules are checked by the bound triangle_asserts module */
`timescale 1ns/1ps

module triangle_tb;
    import gfx_types_pkg::*;
    import scene_pkg::*;

    localparam int DRAW_WAIT = 4;
    localparam int FRAME_LEN = 200;  // cycles between frame ticks
    // 14 frames of 200 cycles plus ~1330 outline pixels at 3 cycles each, with margin
    localparam int TIMEOUT_CYCLES = 20000;

    logic   clk_100m;
    logic   rst_n;
    logic   frame_tick;
    coord_t rd_x;
    coord_t rd_y;
    cidx_t  rd_cidx;
    logic   drawing;
    logic   draw_done;

    int     tick_count;    // frame ticks sent since reset
    int     frame_div;
    logic   tick_en;
    int     cycle_cnt;
    int     test_err;      // failed checks in the running test
    int     tests_passed;
    int     tests_failed;
    pixel_t verts [3];     // vertices of the last shape

    triangle_top #(
        .DRAW_WAIT (DRAW_WAIT),
        .FB_WIDTH  (320),
        .FB_HEIGHT (240)
    ) i_triangle_top (
        .clk_100m  (clk_100m),
        .rst_n     (rst_n),
        .frame_tick(frame_tick),
        .rd_x      (rd_x),
        .rd_y      (rd_y),
        .rd_cidx   (rd_cidx),
        .drawing   (drawing),
        .draw_done (draw_done)
    );

    initial clk_100m = 1'b0;
    always #5 clk_100m = ~clk_100m;

    // one-cycle frame pulse every FRAME_LEN cycles once reset is released
    always @(posedge clk_100m) begin
        tick_en = rst_n;
        #1;
        if (tick_en && frame_div == FRAME_LEN - 1) begin
            frame_tick = 1'b1;
            frame_div  = 0;
            tick_count = tick_count + 1;
        end else begin
            frame_tick = 1'b0;
            if (tick_en) frame_div = frame_div + 1;
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk_100m);
            cycle_cnt = cycle_cnt + 1;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            test_err = test_err + 1;
        end
    endtask

    task automatic end_test(input int num, input string name);
        if (test_err == 0) begin
            tests_passed = tests_passed + 1;
            $display("test %0d %s: ok", num, name);
        end else begin
            tests_failed = tests_failed + 1;
            $display("test %0d %s: FAILED, %0d errors", num, name, test_err);
        end
        test_err = 0;
    endtask

    // present a coordinate, then sample the registered colour mid-cycle
    task automatic read_pixel(input coord_t x, input coord_t y, output cidx_t val);
        @(posedge clk_100m);
        #1;
        rd_x = x;
        rd_y = y;
        @(posedge clk_100m);
        @(negedge clk_100m);
        val = rd_cidx;
    endtask

    initial begin
        logic  seen_draw;
        logic  lost_done;
        int    first_tick;
        cidx_t val;
        rst_n        = 1'b0;
        frame_tick   = 1'b0;
        rd_x         = '0;
        rd_y         = '0;
        tick_count   = 0;
        frame_div    = 0;
        test_err     = 0;
        tests_passed = 0;
        tests_failed = 0;
        verts[0]     = shape_table[2].v0;
        verts[1]     = shape_table[2].v1;
        verts[2]     = shape_table[2].v2;
        repeat (10) @(posedge clk_100m);
        #1;
        rst_n = 1'b1;

        seen_draw = 1'b0;
        while (tick_count < DRAW_WAIT - 1) begin
            @(negedge clk_100m);
            if (drawing) seen_draw = 1'b1;
        end
        read_pixel(16'sd110, 16'sd90, val);
        check_value("rd_cidx at (110,90)", val, 0);
        while (tick_count < DRAW_WAIT) begin
            @(negedge clk_100m);
            if (drawing) seen_draw = 1'b1;
        end
        check_value("drawing before last wait tick", seen_draw, 0);
        end_test(1, "idle during frame wait");

        wait (drawing === 1'b1);
        check_value("frame ticks at drawing rise", tick_count, DRAW_WAIT);
        wait (draw_done === 1'b1);
        @(negedge clk_100m);
        check_value("drawing after draw_done", drawing, 0);
        end_test(2, "drawing runs to draw_done");

        for (int i = 0; i < 3; i++) begin
            read_pixel(verts[i].x, verts[i].y, val);
            check_value($sformatf("rd_cidx at (%0d,%0d)", verts[i].x, verts[i].y),
                        val, shape_table[2].colour);
        end
        end_test(3, "last shape vertices");

        read_pixel(16'sd5, 16'sd235, val);
        check_value("rd_cidx at (5,235)", val, 0);
        read_pixel(16'sd400, 16'sd10, val);
        check_value("rd_cidx at (400,10)", val, 0);
        read_pixel(16'sd380, 16'sd29, val);  // same word as (60,30) if x were not clipped
        check_value("rd_cidx at (380,29)", val, 0);
        end_test(4, "blank and off-screen reads");

        first_tick = tick_count;
        seen_draw  = 1'b0;
        lost_done  = 1'b0;
        while (tick_count < first_tick + 10) begin
            @(negedge clk_100m);
            if (drawing) seen_draw = 1'b1;
            if (!draw_done) lost_done = 1'b1;
        end
        check_value("drawing after completion", seen_draw, 0);
        check_value("draw_done low after completion", lost_done, 0);
        for (int i = 0; i < 3; i++) begin
            read_pixel(verts[i].x, verts[i].y, val);
            check_value($sformatf("rd_cidx again at (%0d,%0d)", verts[i].x, verts[i].y),
                        val, shape_table[2].colour);
        end
        end_test(5, "scene stays put after done");

        $display("tests: %0d passed, %0d failed, %0d assertion failures",
                 tests_passed, tests_failed, i_triangle_top.i_triangle_asserts.fail_cnt);
        if (tests_failed == 0 && i_triangle_top.i_triangle_asserts.fail_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: files.f
logic/gfx_types_pkg.sv
logic/scene_pkg.sv
logic/draw_line.sv
logic/draw_triangle.sv
logic/framebuffer_wb.sv
logic/triangle_scene.sv
logic/triangle_top.sv
dv/triangle_asserts.sv
dv/triangle_tb.sv

// File: logic/draw_line.sv
/* Bresenham line engine for all octants, always walking from the upper endpoint down
   p0 and p1 are sampled one cycle after start; oe low freezes the walk */
`timescale 1ns/1ps

module draw_line (
    input  logic                  clk_100m,
    input  logic                  rst_n,
    input  logic                  start,    // begin a new line
    input  logic                  oe,       // step enable
    input  gfx_types_pkg::pixel_t p0,
    input  gfx_types_pkg::pixel_t p1,
    output gfx_types_pkg::pixel_t pix,      // current point
    output logic                  drawing,  // pix is on the line
    output logic                  done      // pulse after last point
);
    import gfx_types_pkg::*;

    typedef logic signed [19:0] err_t;  // holds 2*err over full coord range
    typedef enum logic [1:0] {ln_idle, ln_init, ln_draw} line_state_t;

    line_state_t state;
    pixel_t      pa;           // upper endpoint
    pixel_t      pb;           // lower endpoint
    pixel_t      cur;
    pixel_t      pend;
    err_t        dx_c;
    err_t        dy_c;
    err_t        dx;
    err_t        dy;
    err_t        err;
    logic        right;        // x steps up
    logic        movx;
    logic        movy;
    logic        last;

    always_comb begin
        pa   = (p0.y > p1.y) ? p1 : p0;
        pb   = (p0.y > p1.y) ? p0 : p1;
        dx_c = (pa.x < pb.x) ? err_t'(pb.x) - err_t'(pa.x)
                             : err_t'(pa.x) - err_t'(pb.x);
        dy_c = err_t'(pa.y) - err_t'(pb.y);  // never positive
    end

    assign movx = (err <<< 1) >= dy;
    assign movy = (err <<< 1) <= dx;
    assign last = (cur == pend);
    assign pix  = cur;

    always_ff @(posedge clk_100m) begin
        if (!rst_n) begin
            state   <= ln_idle;
            drawing <= 1'b0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                ln_init: begin
                    state   <= ln_draw;
                    drawing <= 1'b1;
                end
                ln_draw: if (oe && last) begin
                    state   <= ln_idle;
                    drawing <= 1'b0;
                    done    <= 1'b1;
                end
                default: if (start) state <= ln_init;
            endcase
        end
    end

    // walk state, loaded at init
    always_ff @(posedge clk_100m) begin
        if (state == ln_init) begin
            cur   <= pa;
            pend  <= pb;
            right <= pa.x < pb.x;
            dx    <= dx_c;
            dy    <= dy_c;
            err   <= dx_c + dy_c;
        end else if (state == ln_draw && oe && !last) begin
            if (movx) cur.x <= right ? cur.x + coord_t'(1) : cur.x - coord_t'(1);
            if (movy) cur.y <= cur.y + coord_t'(1);
            err <= err + (movx ? dy : '0) + (movy ? dx : '0);
        end
    end

endmodule

// File: logic/draw_triangle.sv
/* triangle outline engine, edges v0-v1, v1-v2, v2-v0 through one line engine
   shape must stay stable from start until done */
`timescale 1ns/1ps

module draw_triangle (
    input  logic                  clk_100m,
    input  logic                  rst_n,
    input  logic                  start,
    input  logic                  oe,         // freezes the line engine when low
    input  scene_pkg::tri_t       shape,
    output gfx_types_pkg::pixel_t pix,
    output logic                  pix_valid,  // pix taken this cycle
    output logic                  done        // pulse after third edge
);
    import gfx_types_pkg::*;

    typedef enum logic [1:0] {tr_idle, tr_init, tr_draw} tri_state_t;

    tri_state_t state;
    logic [1:0] edge_id;       // 0..2
    logic       line_start;
    logic       line_drawing;
    logic       line_done;
    pixel_t     lp0;
    pixel_t     lp1;

    // endpoints of the current edge
    always_comb begin
        case (edge_id)
            2'd0: begin
                lp0 = shape.v0;
                lp1 = shape.v1;
            end
            2'd1: begin
                lp0 = shape.v1;
                lp1 = shape.v2;
            end
            default: begin
                lp0 = shape.v2;
                lp1 = shape.v0;
            end
        endcase
    end

    always_ff @(posedge clk_100m) begin
        if (!rst_n) begin
            state      <= tr_idle;
            edge_id    <= '0;
            line_start <= 1'b0;
            done       <= 1'b0;
        end else begin
            line_start <= 1'b0;
            done       <= 1'b0;
            case (state)
                tr_init: begin
                    line_start <= 1'b1;
                    state      <= tr_draw;
                end
                tr_draw: if (line_done) begin
                    if (edge_id == 2'd2) begin
                        state <= tr_idle;
                        done  <= 1'b1;
                    end else begin
                        edge_id <= edge_id + 2'd1;
                        state   <= tr_init;
                    end
                end
                default: if (start) begin
                    edge_id <= '0;
                    state   <= tr_init;
                end
            endcase
        end
    end

    draw_line i_draw_line (
        .clk_100m (clk_100m),
        .rst_n    (rst_n),
        .start    (line_start),
        .oe       (oe),
        .p0       (lp0),
        .p1       (lp1),
        .pix      (pix),
        .drawing  (line_drawing),
        .done     (line_done)
    );

    assign pix_valid = line_drawing && oe;

endmodule

// File: logic/framebuffer_wb.sv
/* colour-index framebuffer behind a write-only Wishbone classic slave, one ack per cycle
   writes past the end of memory are dropped; reads off screen return 0 */
`timescale 1ns/1ps

module framebuffer_wb #(
    parameter int FB_WIDTH  = 320,
    parameter int FB_HEIGHT = 240
) (
    input  logic                  clk_100m,
    input  logic                  rst_n,
    input  gfx_types_pkg::wb_wr_t wb,
    output logic                  wb_ack,
    input  gfx_types_pkg::coord_t rd_x,
    input  gfx_types_pkg::coord_t rd_y,
    output gfx_types_pkg::cidx_t  rd_cidx   // one cycle after rd_x/rd_y
);
    import gfx_types_pkg::*;

    localparam int FB_PIXELS = FB_WIDTH * FB_HEIGHT;

    cidx_t    mem [FB_PIXELS];
    logic     wr_req;
    logic     rd_in_fb;
    fb_addr_t rd_addr;

    // blank screen at power-up
    initial begin
        for (int i = 0; i < FB_PIXELS; i++) begin
            mem[i] = '0;
        end
    end

    // first cycle of a strobe, not yet acked
    assign wr_req = wb.cyc && wb.stb && !wb_ack;

    always_ff @(posedge clk_100m) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= wr_req;
        end
    end

    always_ff @(posedge clk_100m) begin
        if (wr_req && wb.we && wb.adr < fb_addr_t'(FB_PIXELS)) begin
            mem[wb.adr] <= wb.dat;
        end
    end

    assign rd_in_fb = (rd_x >= 0) && (rd_x < coord_t'(FB_WIDTH))
                   && (rd_y >= 0) && (rd_y < coord_t'(FB_HEIGHT));
    assign rd_addr  = fb_addr_t'(rd_y) * fb_addr_t'(FB_WIDTH) + fb_addr_t'(rd_x);

    always_ff @(posedge clk_100m) begin
        rd_cidx <= rd_in_fb ? mem[rd_addr] : '0;
    end

endmodule

// File: logic/gfx_types_pkg.sv
/* pixel, colour and bus types shared by the engines and the framebuffer
   fb_addr_t is 17 bits, enough for 320x240 but not for larger framebuffers */
package gfx_types_pkg;

    typedef logic signed [15:0] coord_t;   // screen coordinate, may go negative
    typedef logic [3:0]         cidx_t;    // index into a 16-entry palette
    typedef logic [16:0]        fb_addr_t; // row * width + column

    // one point on the screen, as passed between engines
    typedef struct packed {
        coord_t x;
        coord_t y;
    } pixel_t;

    // Wishbone classic write request, master to slave
    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        fb_addr_t adr;
        cidx_t    dat;
    } wb_wr_t;

endpackage

// File: logic/scene_pkg.sv
/* triangle descriptor, fixed shape table and sequencer states
   the table is drawn in order, so later shapes cover earlier ones */
package scene_pkg;

    localparam int SHAPE_CNT = 3;  // entries in shape_table

    typedef struct packed {
        gfx_types_pkg::pixel_t v0;
        gfx_types_pkg::pixel_t v1;
        gfx_types_pkg::pixel_t v2;
        gfx_types_pkg::cidx_t  colour;
    } tri_t;

    typedef enum logic [1:0] {
        st_idle,   // counting frame ticks
        st_init,   // load next shape
        st_draw,   // triangle engine busy
        st_done    // all shapes drawn
    } scene_state_t;

    localparam tri_t shape_table [SHAPE_CNT] = '{
        '{v0:     '{x: 16'sd20,  y: 16'sd60},
          v1:     '{x: 16'sd60,  y: 16'sd180},
          v2:     '{x: 16'sd110, y: 16'sd90},
          colour: 4'h2},                       // dark purple
        '{v0:     '{x: 16'sd70,  y: 16'sd200},
          v1:     '{x: 16'sd240, y: 16'sd100},
          v2:     '{x: 16'sd170, y: 16'sd10},
          colour: 4'hC},                       // blue
        '{v0:     '{x: 16'sd60,  y: 16'sd30},
          v1:     '{x: 16'sd300, y: 16'sd80},
          v2:     '{x: 16'sd160, y: 16'sd220},
          colour: 4'h9}                        // orange
    };

endpackage

// File: logic/triangle_scene.sv
/* scene sequencer: waits DRAW_WAIT frame ticks, draws shape_table once, then stays done
   one Wishbone write in flight at a time; the engines stall while it is open */
`timescale 1ns/1ps

module triangle_scene #(
    parameter int DRAW_WAIT = 300,
    parameter int FB_WIDTH  = 320,
    parameter int FB_HEIGHT = 240
) (
    input  logic                  clk_100m,
    input  logic                  rst_n,
    input  logic                  frame_tick,  // one pulse per frame
    output scene_pkg::tri_t       shape,
    output logic                  tri_start,
    output logic                  tri_oe,
    input  gfx_types_pkg::pixel_t pix,
    input  logic                  pix_valid,
    input  logic                  tri_done,
    output gfx_types_pkg::wb_wr_t wb,
    input  logic                  wb_ack,
    output logic                  drawing,
    output logic                  draw_done
);
    import gfx_types_pkg::*;
    import scene_pkg::*;

    localparam int WAIT_W = $clog2(DRAW_WAIT + 1);
    localparam int SID_W  = $clog2(SHAPE_CNT);

    scene_state_t     state;
    logic [WAIT_W-1:0] wait_cnt;   // frame ticks seen
    logic [SID_W-1:0]  shape_id;
    logic              wb_cyc;
    fb_addr_t          wb_adr;
    cidx_t             wb_dat;
    logic              pix_in_fb;
    fb_addr_t          pix_addr;

    always_ff @(posedge clk_100m) begin
        if (!rst_n) begin
            state     <= st_idle;
            wait_cnt  <= '0;
            shape_id  <= '0;
            tri_start <= 1'b0;
            drawing   <= 1'b0;
            draw_done <= 1'b0;
        end else begin
            tri_start <= 1'b0;
            case (state)
                st_idle: if (frame_tick) begin
                    wait_cnt <= wait_cnt + 1'b1;
                    if (wait_cnt == WAIT_W'(DRAW_WAIT - 1)) state <= st_init;
                end
                st_init: begin
                    tri_start <= 1'b1;
                    drawing   <= 1'b1;
                    state     <= st_draw;
                end
                st_draw: if (tri_done) begin
                    if (shape_id == SID_W'(SHAPE_CNT - 1)) begin
                        drawing   <= 1'b0;
                        draw_done <= 1'b1;
                        state     <= st_done;
                    end else begin
                        shape_id <= shape_id + 1'b1;
                        state    <= st_init;
                    end
                end
                default: state <= st_done;  // sticky until reset
            endcase
        end
    end

    // descriptor held for the whole triangle
    always_ff @(posedge clk_100m) begin
        if (state == st_init) shape <= shape_table[shape_id];
    end

    assign pix_in_fb = (pix.x >= 0) && (pix.x < coord_t'(FB_WIDTH))
                    && (pix.y >= 0) && (pix.y < coord_t'(FB_HEIGHT));
    assign pix_addr  = fb_addr_t'(pix.y) * fb_addr_t'(FB_WIDTH) + fb_addr_t'(pix.x);

    always_ff @(posedge clk_100m) begin
        if (!rst_n) begin
            wb_cyc <= 1'b0;
        end else if (wb_cyc) begin
            if (wb_ack) wb_cyc <= 1'b0;   // close cycle after ack
        end else if (pix_valid && pix_in_fb) begin
            wb_cyc <= 1'b1;
        end
    end

    always_ff @(posedge clk_100m) begin
        if (!wb_cyc && pix_valid) begin
            wb_adr <= pix_addr;
            wb_dat <= shape.colour;
        end
    end

    always_comb begin
        wb.cyc = wb_cyc;
        wb.stb = wb_cyc;   // single transfer per cycle
        wb.we  = wb_cyc;
        wb.adr = wb_adr;
        wb.dat = wb_dat;
    end

    assign tri_oe = !wb_cyc;

endmodule

// File: logic/triangle_top.sv
/* drawing core: scene sequencer, triangle engine and framebuffer on one clock
   frame_tick must already be a single-cycle pulse in the clk_100m domain */
`timescale 1ns/1ps

module triangle_top #(
    parameter int DRAW_WAIT = 300,  // frames before drawing starts
    parameter int FB_WIDTH  = 320,
    parameter int FB_HEIGHT = 240
) (
    input  logic                  clk_100m,
    input  logic                  rst_n,
    input  logic                  frame_tick,
    input  gfx_types_pkg::coord_t rd_x,
    input  gfx_types_pkg::coord_t rd_y,
    output gfx_types_pkg::cidx_t  rd_cidx,
    output logic                  drawing,
    output logic                  draw_done
);
    import gfx_types_pkg::*;
    import scene_pkg::*;

    tri_t   shape;
    logic   tri_start;
    logic   tri_oe;
    logic   tri_done;
    pixel_t pix;
    logic   pix_valid;
    wb_wr_t wb;
    logic   wb_ack;

    triangle_scene #(
        .DRAW_WAIT (DRAW_WAIT),
        .FB_WIDTH  (FB_WIDTH),
        .FB_HEIGHT (FB_HEIGHT)
    ) i_triangle_scene (
        .clk_100m  (clk_100m),
        .rst_n     (rst_n),
        .frame_tick(frame_tick),
        .shape     (shape),
        .tri_start (tri_start),
        .tri_oe    (tri_oe),
        .pix       (pix),
        .pix_valid (pix_valid),
        .tri_done  (tri_done),
        .wb        (wb),
        .wb_ack    (wb_ack),
        .drawing   (drawing),
        .draw_done (draw_done)
    );

    draw_triangle i_draw_triangle (
        .clk_100m (clk_100m),
        .rst_n    (rst_n),
        .start    (tri_start),
        .oe       (tri_oe),
        .shape    (shape),
        .pix      (pix),
        .pix_valid(pix_valid),
        .done     (tri_done)
    );

    framebuffer_wb #(
        .FB_WIDTH (FB_WIDTH),
        .FB_HEIGHT(FB_HEIGHT)
    ) i_framebuffer_wb (
        .clk_100m(clk_100m),
        .rst_n   (rst_n),
        .wb      (wb),
        .wb_ack  (wb_ack),
        .rd_x    (rd_x),
        .rd_y    (rd_y),
        .rd_cidx (rd_cidx)
    );

endmodule

// File: run_sim.sh
#!/bin/sh
# build triangle_tb with Verilator, run it, and judge the log
verilator --binary --timing --assert -Wno-fatal --top-module triangle_tb \
    -Mdir obj_dir -f files.f \
    || { echo "verilator build failed"; exit 1; }
./obj_dir/Vtriangle_tb +verilator+error+limit+1000 > sim.log 2>&1 \
    || echo "simulator exited with an error status"
cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1
grep -q "STATUS: PASS" sim.log || { echo "no status line in sim.log"; exit 1; }
exit 0
